// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = tbIcache
FILELIST = sources.f
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST)) icache_settings.svh

.PHONY: all run clean

all: run

run: $(BIN)
	./$(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// ==== busFill.sv ====
/*
  Bus side: beat address generation for fills and bypass reads,
  plus the address-to-data offset register for the pipelined bus
*/
module busFill (
  input  logic                   clk,
  input  logic                   reset,
  input  icachePkg::fetchFieldsT fields,
  input  icachePkg::offsetT      fillCounter,
  input  logic                   fillActive,
  input  logic                   bypassRead,
  input  logic                   busReady,
  input  icachePkg::wordT        busRData,
  output icachePkg::busBeatT     beat,
  output icachePkg::wordT        fillData,
  output icachePkg::offsetT      fillOffset
);
  import icachePkg::*;

  offsetT beatOffset;
  offsetT dataOffset;
  logic   dataPending;

  // Fill walks the line, bypass reads only the requested word
  assign beatOffset = fillActive ? fillCounter : fields.offset;

  always_comb begin
    beat.addr = {fields.tag, fields.index, beatOffset, 2'b00};
    beat.valid = fillActive | bypassRead;
  end

  // One address phase in flight, its data arrives on the next busReady
  always_ff @(posedge clk) begin
    if (reset) begin
      dataOffset <= '0;
      dataPending <= 1'b0;
    end else if (busReady) begin
      dataOffset <= beatOffset;
      dataPending <= beat.valid;
    end
  end

  // Word only counts while a data phase is open
  assign fillData = dataPending ? busRData : '0;
  assign fillOffset = dataOffset;

  requestHeld: assert property (@(posedge clk) disable iff (reset)
    (beat.valid && !busReady) |=> (beat.valid && $stable(beat.addr)));

endmodule

// ==== fetchRequest.sv ====
/*
  Fetch side of the cache: address register, pending flag and
  the split into tag, index and word offset
*/
module fetchRequest (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   fetchValid,
  input  icachePkg::addrT        fetchAddr,
  input  logic                   fetchDone,
  output icachePkg::fetchFieldsT fields
);
  import icachePkg::*;

  addrT addrReg;
  logic pending;
  logic capture;

  // A new address is taken only while no fetch is open
  assign capture = fetchValid & ~pending;

  // Done wins, so the flag stays low for one cycle before the next capture
  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= 1'b0;
    end else if (fetchDone) begin
      pending <= 1'b0;
    end else if (capture) begin
      pending <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      addrReg <= fetchAddr;
    end
  end

  // Byte bits are dropped, the rest maps straight onto the fields
  always_comb begin
    {fields.tag, fields.index, fields.offset} = addrReg[$bits(addrT)-1:2];
    fields.addrReady = pending;
  end

  // Processor holds the address until the word comes back
  addrHeld: assert property (@(posedge clk) disable iff (reset)
    (pending && !fetchDone) |-> (fetchAddr == addrReg));

endmodule

// ==== icacheArray.sv ====
/*
  Two-way tag, valid, data and LRU storage, written on the clock
  and read asynchronously at the registered index and offset
*/
`include "icache_settings.svh"

module icacheArray (
  input  logic                   clk,
  input  logic                   reset,
  input  icachePkg::fetchFieldsT fields,
  input  icachePkg::arrayWriteT  write,
  output icachePkg::wayLookupT   lookup
);
  import icachePkg::*;

  localparam int NumSets = 1 << `ICACHE_SET_BITS;
  localparam int NumWords = NumSets << `ICACHE_OFFSET_BITS;

  // Entry 0 holds way 1, entry 1 holds way 2
  tagT                tagMem    [2][NumSets];
  wordT               dataMem   [2][NumWords];
  logic [NumSets-1:0] validBits [2];
  logic [NumSets-1:0] lruBits;
  logic [1:0]         wayWrite;
  logic [1:0]         wayValid;
  tagT                wayTag    [2];
  wordT               wayData   [2];

  assign wayWrite = {write.write2, write.write1};

  // Line data and tags
  always_ff @(posedge clk) begin
    for (int w = 0; w < 2; w++) begin
      if (wayWrite[w]) begin
        dataMem[w][{write.index, write.offset}] <= write.data;
        if (write.tagWrite) begin
          tagMem[w][write.index] <= write.tag;
        end
      end
    end
  end

  // Valid and LRU bits start cleared
  always_ff @(posedge clk) begin
    if (reset) begin
      validBits[0] <= '0;
      validBits[1] <= '0;
      lruBits <= '0;
    end else begin
      for (int w = 0; w < 2; w++) begin
        if (wayWrite[w] && write.validSet) begin
          validBits[w][write.index] <= 1'b1;
        end
      end
      if (write.lruWrite) begin
        lruBits[write.index] <= write.lruValue;
      end
    end
  end

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      wayValid[w] = validBits[w][fields.index];
      wayTag[w] = tagMem[w][fields.index];
      wayData[w] = dataMem[w][{fields.index, fields.offset}];
    end
  end

  always_comb begin
    lookup.valid1 = wayValid[0];
    lookup.tag1 = wayTag[0];
    lookup.valid2 = wayValid[1];
    lookup.tag2 = wayTag[1];
    lookup.data1 = wayData[0];
    lookup.data2 = wayData[1];
    // Set means way 2 is the one to replace next
    lookup.lru = lruBits[fields.index];
  end

endmodule

// ==== icacheController.sv ====
/*
  Cache controller: miss FSM, hit detection, way and victim choice,
  address-phase fill counter and array write control
*/
module icacheController (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   enable,
  input  icachePkg::fetchFieldsT fields,
  input  icachePkg::wayLookupT   lookup,
  input  logic                   busReady,
  input  icachePkg::wordT        fillData,
  input  icachePkg::offsetT      fillOffset,
  output logic                   stall,
  output logic                   instrValid,
  output icachePkg::wordT        instr,
  output logic                   fetchDone,
  output icachePkg::arrayWriteT  arrayWrite,
  output icachePkg::offsetT      fillCounter,
  output logic                   fillActive,
  output logic                   bypassRead
);
  import icachePkg::*;

  ctrlStateT state;
  ctrlStateT nextState;
  logic      hit1;
  logic      hit2;
  logic      hit;
  logic      victim2;
  logic      dataBeat;
  logic      lastBeat;
  logic      bypassIssued;
  logic      bypassDone;
  wordT      capturedWord;

  // Tag compare on both ways, only for a stable fetch with the cache on
  assign hit1 = lookup.valid1 & (lookup.tag1 == fields.tag);
  assign hit2 = lookup.valid2 & (lookup.tag2 == fields.tag);
  assign hit = (hit1 | hit2) & fields.addrReady & enable;

  // Empty way first, way 1 before way 2, otherwise the one LRU names
  assign victim2 = lookup.valid1 & (~lookup.valid2 | lookup.lru);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ready;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      ready: begin
        if (fields.addrReady && !hit) begin
          nextState = enable ? memRead : lastRead;
        end
      end
      memRead: begin
        // Address phase of the last word in the line accepted
        if (busReady && fillCounter == '1) begin
          nextState = lastRead;
        end
      end
      lastRead: begin
        if (busReady && (enable || bypassIssued)) begin
          nextState = nextInstr;
        end
      end
      default: begin
        nextState = ready;
      end
    endcase
  end

  assign fillActive = (state == memRead);
  assign bypassRead = (state == lastRead) & ~enable & ~bypassIssued;
  assign instrValid = ((state == ready) & hit) | (state == nextInstr);
  assign fetchDone = instrValid;
  assign stall = fields.addrReady & ~instrValid;

  // After a fill the lookup hits, so the way mux serves both cases
  assign instr = ((state == nextInstr) && !enable) ? capturedWord :
                 (hit1 ? lookup.data1 : lookup.data2);

  // Counts accepted address phases of a line fill
  always_ff @(posedge clk) begin
    if (reset || hit || state == nextInstr || !enable) begin
      fillCounter <= '0;
    end else if (fillActive && busReady) begin
      fillCounter <= fillCounter + offsetT'(1);
    end
  end

  // Bypass read, one address phase then its data phase
  assign bypassDone = (state == lastRead) & ~enable & bypassIssued & busReady;

  always_ff @(posedge clk) begin
    if (reset || state == nextInstr) begin
      bypassIssued <= 1'b0;
    end else if (bypassRead && busReady) begin
      bypassIssued <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (bypassDone) begin
      capturedWord <= fillData;
    end
  end

  // Data returns from the second address phase on, the last one in lastRead
  assign dataBeat = enable & busReady &
                    (((state == memRead) & (fillCounter != '0)) | (state == lastRead));
  assign lastBeat = dataBeat & (state == lastRead);

  always_comb begin
    arrayWrite.write1 = dataBeat & ~victim2;
    arrayWrite.write2 = dataBeat & victim2;
    arrayWrite.index = fields.index;
    arrayWrite.offset = fillOffset;
    arrayWrite.data = fillData;
    arrayWrite.tag = fields.tag;
    arrayWrite.tagWrite = lastBeat;
    arrayWrite.validSet = lastBeat;
    // Hit or finished fill makes the other way least recently used
    arrayWrite.lruWrite = ((state == ready) & hit) | lastBeat;
    arrayWrite.lruValue = (state == ready) ? hit1 : ~victim2;
  end

  oneWayWrite: assert property (@(posedge clk) disable iff (reset)
    !(arrayWrite.write1 && arrayWrite.write2));

  // Past the first beat the counter only moves on busReady
  counterHeld: assert property (@(posedge clk) disable iff (reset)
    ((state == memRead || state == lastRead) && !busReady)
      |=> (fillCounter == $past(fillCounter)));

endmodule

// ==== icachePkg.sv ====
/*
  Shared cache types: address fields, controller states and the
  structs passed between fetch side, controller, arrays and bus side
*/
`include "icache_settings.svh"

package icachePkg;

  typedef logic [`ICACHE_ADDR_WIDTH-1:0] addrT;
  // Tag sits above index, word offset and the two byte bits
  typedef logic [`ICACHE_ADDR_WIDTH-`ICACHE_SET_BITS-`ICACHE_OFFSET_BITS-3:0] tagT;
  typedef logic [`ICACHE_SET_BITS-1:0] indexT;
  typedef logic [`ICACHE_OFFSET_BITS-1:0] offsetT;
  typedef logic [`ICACHE_WORD_WIDTH-1:0] wordT;

  typedef enum logic [1:0] {
    ready,
    memRead,
    lastRead,
    nextInstr
  } ctrlStateT;

  typedef struct packed {
    tagT    tag;
    indexT  index;
    offsetT offset;
    logic   addrReady;
  } fetchFieldsT;

  typedef struct packed {
    logic valid1;
    tagT  tag1;
    logic valid2;
    tagT  tag2;
    wordT data1;
    wordT data2;
    logic lru;
  } wayLookupT;

  typedef struct packed {
    logic   write1;
    logic   write2;
    indexT  index;
    offsetT offset;
    wordT   data;
    tagT    tag;
    logic   tagWrite;
    logic   validSet;
    logic   lruWrite;
    logic   lruValue;
  } arrayWriteT;

  typedef struct packed {
    addrT addr;
    logic valid;
  } busBeatT;

endpackage

// ==== icacheTop.sv ====
/*
  Instruction cache top: fetch side, controller, arrays and bus side
*/
module icacheTop (
  input  logic            clk,
  input  logic            reset,
  input  logic            enable,
  input  logic            fetchValid,
  input  icachePkg::addrT fetchAddr,
  input  logic            busReady,
  input  icachePkg::wordT busRData,
  output logic            stall,
  output logic            instrValid,
  output icachePkg::wordT instr,
  output logic            busRequest,
  output icachePkg::addrT busAddr
);
  import icachePkg::*;

  fetchFieldsT fields;
  wayLookupT   lookup;
  arrayWriteT  arrayWrite;
  busBeatT     beat;
  wordT        fillData;
  offsetT      fillOffset;
  offsetT      fillCounter;
  logic        fetchDone;
  logic        fillActive;
  logic        bypassRead;

  fetchRequest i_fetchRequest (
    .clk        (clk),
    .reset      (reset),
    .fetchValid (fetchValid),
    .fetchAddr  (fetchAddr),
    .fetchDone  (fetchDone),
    .fields     (fields)
  );

  icacheController i_icacheController (
    .clk         (clk),
    .reset       (reset),
    .enable      (enable),
    .fields      (fields),
    .lookup      (lookup),
    .busReady    (busReady),
    .fillData    (fillData),
    .fillOffset  (fillOffset),
    .stall       (stall),
    .instrValid  (instrValid),
    .instr       (instr),
    .fetchDone   (fetchDone),
    .arrayWrite  (arrayWrite),
    .fillCounter (fillCounter),
    .fillActive  (fillActive),
    .bypassRead  (bypassRead)
  );

  icacheArray i_icacheArray (
    .clk    (clk),
    .reset  (reset),
    .fields (fields),
    .write  (arrayWrite),
    .lookup (lookup)
  );

  busFill i_busFill (
    .clk         (clk),
    .reset       (reset),
    .fields      (fields),
    .fillCounter (fillCounter),
    .fillActive  (fillActive),
    .bypassRead  (bypassRead),
    .busReady    (busReady),
    .busRData    (busRData),
    .beat        (beat),
    .fillData    (fillData),
    .fillOffset  (fillOffset)
  );

  assign busRequest = beat.valid;
  assign busAddr = beat.addr;

endmodule

// ==== icache_settings.svh ====
/*
  Cache geometry and address layout macros
*/
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// Physical byte address width
`define ICACHE_ADDR_WIDTH 32

// Index width, 64 sets of two ways
`define ICACHE_SET_BITS 6

// Word offset width, four words per line
`define ICACHE_OFFSET_BITS 2

// Instruction and bus data word
`define ICACHE_WORD_WIDTH 32

`endif

// ==== sources.f ====
+incdir+.
icachePkg.sv
fetchRequest.sv
icacheController.sv
icacheArray.sv
busFill.sv
icacheTop.sv
tbBusMemory.sv
tbIcache.sv

// ==== tbBusMemory.sv ====
/*
  Pipelined bus memory model with LFSR wait states,
  address-derived read data and a count of accepted address phases
*/
module tbBusMemory #(
  parameter icachePkg::wordT DataKey = '0
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            busRequest,
  input  icachePkg::addrT busAddr,
  output logic            busReady,
  output icachePkg::wordT busRData,
  output int              beatCount
);
  timeunit 1ns;
  timeprecision 1ps;
  import icachePkg::*;

  logic [15:0] lfsr = 16'd57;
  logic        readyReg = 1'b0;
  wordT        rdataReg = '0;
  logic        armed = 1'b0;
  logic        dataOwed;
  addrT        owedAddr;
  int          waitLeft;

  assign busReady = readyReg;
  assign busRData = rdataReg;

  // Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic wordT memWord(input addrT a);
    return wordT'(a >> 2) ^ DataKey;
  endfunction

  // Strobe taken on this edge closes the address phase and its data phase
  always @(posedge clk) begin
    if (reset) begin
      dataOwed <= 1'b0;
      owedAddr <= '0;
      beatCount <= 0;
    end else if (readyReg) begin
      dataOwed <= busRequest;
      owedAddr <= busAddr;
      if (busRequest) begin
        beatCount <= beatCount + 1;
      end
    end
  end

  always @(negedge clk) begin
    if (reset) begin
      readyReg <= 1'b0;
      armed = 1'b0;
    end else begin
      if (readyReg) begin
        armed = 1'b0;
      end
      // Two LFSR bits give zero to three wait states for the next strobe
      if ((busRequest || dataOwed) && !armed) begin
        lfsr = lfsrNext(lfsr);
        waitLeft = int'(lfsr[0]);
        lfsr = lfsrNext(lfsr);
        waitLeft = waitLeft * 2 + int'(lfsr[0]);
        armed = 1'b1;
      end
      if (armed && waitLeft == 0) begin
        readyReg <= 1'b1;
        rdataReg <= dataOwed ? memWord(owedAddr) : '0;
      end else begin
        readyReg <= 1'b0;
        if (armed) begin
          waitLeft--;
        end
      end
    end
  end

endmodule

// ==== tbIcache.sv ====
/*
  Instruction cache testbench: clock, reset, reference cache model,
  stimulus table applied in a loop, compare tasks and timeout
*/
module tbIcache;
  timeunit 1ns;
  timeprecision 1ps;
  import icachePkg::*;

  typedef logic [$bits(offsetT):0] beatT;

  typedef struct packed {
    logic enable;
    addrT addr;
    wordT word;
    beatT beats;
  } rowT;

  localparam wordT DataKey = 32'h5A3C_96E1;
  localparam int NumSets = 1 << $bits(indexT);

  logic clk = 1'b0;
  logic reset;
  logic enable;
  logic fetchValid;
  addrT fetchAddr;
  logic busReady;
  wordT busRData;
  logic stall;
  logic instrValid;
  wordT instr;
  logic busRequest;
  addrT busAddr;
  int   beatCount;
  int   cycleCount;
  int   cycleLimit;
  rowT  rows[$];

  // Reference model state, way 0 is way 1 of the design
  logic modelValid [2][NumSets];
  tagT  modelTag   [2][NumSets];
  logic modelLru   [NumSets];

  icacheTop i_icacheTop (
    .clk        (clk),
    .reset      (reset),
    .enable     (enable),
    .fetchValid (fetchValid),
    .fetchAddr  (fetchAddr),
    .busReady   (busReady),
    .busRData   (busRData),
    .stall      (stall),
    .instrValid (instrValid),
    .instr      (instr),
    .busRequest (busRequest),
    .busAddr    (busAddr)
  );

  tbBusMemory #(.DataKey(DataKey)) busMemory (
    .clk        (clk),
    .reset      (reset),
    .busRequest (busRequest),
    .busAddr    (busAddr),
    .busReady   (busReady),
    .busRData   (busRData),
    .beatCount  (beatCount)
  );

  always #20 clk = ~clk;

  task automatic failRun(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic wordCheck(input string name, input wordT expected, input wordT actual);
    if (actual !== expected) begin
      failRun($sformatf("Mismatch %s: expected %h, got %h", name, expected, actual));
    end
  endtask

  task automatic addrCheck(input string name, input addrT expected, input addrT actual);
    if (actual !== expected) begin
      failRun($sformatf("Mismatch %s: expected %h, got %h", name, expected, actual));
    end
  endtask

  task automatic beatCheck(input string name, input beatT expected, input beatT actual);
    if (actual !== expected) begin
      failRun($sformatf("Mismatch %s: expected %h, got %h", name, expected, actual));
    end
  endtask

  task automatic flagCheck(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      failRun($sformatf("Mismatch %s: expected %h, got %h", name, expected, actual));
    end
  endtask

  function automatic wordT expectedWord(input addrT addr);
    return wordT'(addr >> 2) ^ DataKey;
  endfunction

  // A fill walks the line from word 0, a bypass read asks for the fetched word only
  function automatic addrT expectedBusAddr(input rowT row, input int beatsDone);
    if (!row.enable) begin
      return row.addr;
    end else begin
      return {row.addr[$bits(addrT)-1:$bits(offsetT)+2], offsetT'(beatsDone), 2'b00};
    end
  endfunction

  // Runs the fetch through the model, then stores it with its expected results
  task automatic addRow(input logic en, input addrT addr);
    rowT   row;
    tagT   tag;
    indexT idx;
    int    way;
    {tag, idx} = addr[$bits(addrT)-1:$bits(offsetT)+2];
    row.enable = en;
    row.addr = addr;
    row.word = expectedWord(addr);
    if (!en) begin
      row.beats = beatT'(1);
    end else begin
      way = -1;
      for (int w = 0; w < 2; w++) begin
        if (modelValid[w][idx] && modelTag[w][idx] == tag) begin
          way = w;
        end
      end
      if (way >= 0) begin
        row.beats = beatT'(0);
      end else begin
        row.beats = beatT'(4);
        way = !modelValid[0][idx] ? 0 : (!modelValid[1][idx] ? 1 : int'(modelLru[idx]));
        modelValid[way][idx] = 1'b1;
        modelTag[way][idx] = tag;
      end
      // Set means way 2 goes next
      modelLru[idx] = (way == 0);
    end
    rows.push_back(row);
  endtask

  task automatic buildTable();
    foreach (modelValid[w, s]) begin
      modelValid[w][s] = 1'b0;
    end
    foreach (modelLru[s]) begin
      modelLru[s] = 1'b0;
    end
    // First line, then its other words
    addRow(1'b1, 32'h0000_1040);
    addRow(1'b1, 32'h0000_1044);
    addRow(1'b1, 32'h0000_1048);
    addRow(1'b1, 32'h0000_104C);
    // Three tags on set 4
    addRow(1'b1, 32'h0000_2040);
    addRow(1'b1, 32'h0000_1048);
    addRow(1'b1, 32'h0000_3040);
    addRow(1'b1, 32'h0000_104C);
    addRow(1'b1, 32'h0000_2044);
    addRow(1'b1, 32'h0000_1040);
    // Bypass reads, then the same line enabled
    addRow(1'b0, 32'h0000_05A0);
    addRow(1'b0, 32'h0000_05AC);
    addRow(1'b1, 32'h0000_05A8);
    addRow(1'b1, 32'h0000_05A0);
    addRow(1'b0, 32'h0000_1044);
    addRow(1'b1, 32'h0000_3048);
    addRow(1'b1, 32'h0000_2048);
    // Eight tags thrashing one set, twice
    for (int pass = 0; pass < 2; pass++) begin
      for (int i = 0; i < 8; i++) begin
        addRow(1'b1, addrT'(32'h0004_0000 + i * 32'h0000_0400 + (i % 4) * 4));
      end
    end
  endtask

  always @(posedge clk) begin
    cycleCount++;
    if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
      failRun("Timeout, the cache did not return an instruction within the cycle limit");
    end
  end

  initial begin
    int beatsStart;
    reset = 1'b1;
    enable = 1'b0;
    fetchValid = 1'b0;
    fetchAddr = '0;
    buildTable();
    // Worst case per row is five strobes of four cycles plus overhead
    cycleLimit = rows.size() * 4 * 4 + rows.size() * 8 + 50;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    flagCheck("stall", 1'b0, stall);
    flagCheck("instrValid", 1'b0, instrValid);
    flagCheck("busRequest", 1'b0, busRequest);
    foreach (rows[i]) begin
      enable = rows[i].enable;
      fetchAddr = rows[i].addr;
      fetchValid = 1'b1;
      beatsStart = beatCount;
      @(negedge clk);
      while (!instrValid) begin
        flagCheck("stall", 1'b1, stall);
        if (busRequest) begin
          addrCheck("busAddr", expectedBusAddr(rows[i], beatCount - beatsStart), busAddr);
        end
        @(negedge clk);
      end
      flagCheck("stall", 1'b0, stall);
      wordCheck("instr", rows[i].word, instr);
      beatCheck("busBeats", rows[i].beats, beatT'(beatCount - beatsStart));
      // Enable only changes once the fetch is closed
      fetchValid = 1'b0;
      @(negedge clk);
      // instrValid is a single-cycle pulse
      flagCheck("instrValid", 1'b0, instrValid);
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule
